//--- compile.f
rtl/div_pkg.sv
rtl/apb_pkg.sv
rtl/apb_reg_decode.sv
rtl/div_array_execute.sv
rtl/div_result_regs.sv
rtl/div_apb_top.sv
verification/div_assertions.sv
verification/div_tb.sv

//--- rtl/apb_pkg.sv
`default_nettype none

package apb_pkg;

  localparam int unsigned addr_width = 4;
  localparam int unsigned data_width = 32;

  // register offsets.
  localparam logic [addr_width-1:0] addr_operands = 4'h0;  // write only, starts a job.
  localparam logic [addr_width-1:0] addr_result   = 4'h4;  // read only.
  localparam logic [addr_width-1:0] addr_status   = 4'h8;  // read only.
  localparam logic [addr_width-1:0] addr_mode     = 4'hC;

  // Requester side of the bus, driven by the host.
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [addr_width-1:0] paddr;
    logic [data_width-1:0] pwdata;
  } apb_req_t;

  // completer side of the bus.
  typedef struct packed {
    logic [data_width-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

//--- rtl/apb_reg_decode.sv
`timescale 1ns/1ns
`default_nettype none

module apb_reg_decode (
  input  logic              clk,
  input  logic              reset,
  input  apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t apb_rsp,
  output logic              start,
  output div_pkg::div_op_t  op,
  output logic              clear,
  input  div_pkg::div_res_t result,
  input  logic              done
);

  logic access;
  logic write_access;
  logic allowed;      // offset exists and the direction is legal for it.
  logic approx_mode;

  // pready is tied high, so every access phase lasts a single cycle.
  assign access       = apb_req.psel & apb_req.penable;
  assign write_access = access & apb_req.pwrite;

  always_comb begin
    case (apb_req.paddr)
      apb_pkg::addr_operands: allowed = apb_req.pwrite;
      apb_pkg::addr_result,
      apb_pkg::addr_status:   allowed = ~apb_req.pwrite;
      apb_pkg::addr_mode:     allowed = 1'b1;
      default:                allowed = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      approx_mode <= 1'b1;  // the approximate cells are the power-on choice.
    end else if (write_access && apb_req.paddr == apb_pkg::addr_mode) begin
      approx_mode <= apb_req.pwdata[0];
    end
  end

  // The job is captured by the execute stage on this same edge.
  assign start = write_access && (apb_req.paddr == apb_pkg::addr_operands);

  // a new job retires the done flag of the previous one.
  assign clear = write_access && (apb_req.paddr == apb_pkg::addr_operands);

  assign op.dividend = apb_req.pwdata[div_pkg::dividend_width-1:0];
  assign op.divisor  = apb_req.pwdata[div_pkg::dividend_width +: div_pkg::divisor_width];
  assign op.approx   = approx_mode;

  always_comb begin
    apb_rsp.prdata = '0;
    case (apb_req.paddr)
      apb_pkg::addr_result: begin
        apb_rsp.prdata[2*div_pkg::divisor_width-1:0] = {result.remainder, result.quotient};
      end
      apb_pkg::addr_status: begin
        apb_rsp.prdata[1:0] = {result.div_by_zero, done};
      end
      apb_pkg::addr_mode: begin
        apb_rsp.prdata[0] = approx_mode;
      end
      default: begin
        apb_rsp.prdata = '0;  // write-only and unmapped offsets read as zero.
      end
    endcase
  end

  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access & ~allowed;

endmodule

`default_nettype wire

//--- rtl/div_apb_top.sv
`timescale 1ns/1ns
`default_nettype none

module div_apb_top (
  input  logic              clk,
  input  logic              reset,
  input  apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t apb_rsp
);

  logic              start;
  logic              clear;
  logic              valid;
  logic              done;
  div_pkg::div_op_t  op;
  div_pkg::div_res_t exec_result;
  div_pkg::div_res_t held_result;  // what the host reads back.

  apb_reg_decode decode_i (
    .clk     (clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .start   (start),
    .op      (op),
    .clear   (clear),
    .result  (held_result),
    .done    (done)
  );

  div_array_execute execute_i (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .op     (op),
    .valid  (valid),
    .result (exec_result)
  );

  div_result_regs result_i (
    .clk       (clk),
    .reset     (reset),
    .clear     (clear),
    .valid     (valid),
    .result_in (exec_result),
    .result    (held_result),
    .done      (done)
  );

endmodule

`default_nettype wire

//--- rtl/div_array_execute.sv
`timescale 1ns/1ns
`default_nettype none

module div_array_execute (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  div_pkg::div_op_t  op,
  output logic              valid,
  output div_pkg::div_res_t result
);

  div_pkg::div_op_t op_q;
  logic             start_q;
  logic [div_pkg::divisor_width-1:0] quotient;
  logic [div_pkg::divisor_width-1:0] remainder;

  always_ff @(posedge clk) begin
    if (reset) begin
      start_q <= 1'b0;
      valid   <= 1'b0;
    end else begin
      start_q <= start;
      valid   <= start_q;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op_q <= op;
    end
    if (start_q) begin
      result.quotient    <= quotient;
      result.remainder   <= remainder;
      result.div_by_zero <= (op_q.divisor == '0);  // flagged only, the array still runs.
    end
  end

  // Restoring triangular array. Row i yields quotient bit i and hands its partial
  // remainder down to row i-1, and row 0 holds the final remainder.
  for (genvar i = 0; i < div_pkg::divisor_width; i++) begin : row
    logic q;

    for (genvar j = 0; j < div_pkg::divisor_width; j++) begin : col
      logic x;
      logic y;
      logic bin;
      logic diff;
      logic bout;
      logic rem;
      logic use_approx;

      assign y = op_q.divisor[j];

      if (j == 0) begin : g_first
        assign x   = op_q.dividend[i];
        assign bin = 1'b0;
      end else begin : g_chain
        assign bin = row[i].col[j-1].bout;
        if (i == div_pkg::divisor_width - 1) begin : g_top
          assign x = op_q.dividend[div_pkg::divisor_width - 1 + j];
        end else begin : g_below
          assign x = row[i+1].col[j-1].rem;
        end
      end

      assign use_approx = div_pkg::approx_cells[i][j] & op_q.approx;

      // the approximate cell keeps x as its difference and ors the incoming borrow.
      assign diff = use_approx ? x : (x ^ y ^ bin);
      assign bout = use_approx ? (bin | (~x & y)) : ((~x & y) | (~(x ^ y) & bin));
      assign rem  = q ? diff : x;  // restore when the row does not subtract.
    end

    // A set high bit means the shifted remainder already exceeds the divisor.
    if (i == div_pkg::divisor_width - 1) begin : g_top_q
      assign q = op_q.dividend[div_pkg::dividend_width-1] |
                 ~row[i].col[div_pkg::divisor_width-1].bout;
    end else begin : g_low_q
      assign q = row[i+1].col[div_pkg::divisor_width-1].rem |
                 ~row[i].col[div_pkg::divisor_width-1].bout;
    end

    assign quotient[i]  = q;
    assign remainder[i] = row[0].col[i].rem;
  end

endmodule

`default_nettype wire

//--- rtl/div_pkg.sv
`default_nettype none

package div_pkg;

  localparam int unsigned dividend_width = 16;
  localparam int unsigned divisor_width  = 8;  // also the quotient and remainder width.

  // approx_cells[row][col] marks the cells that may switch to the approximate subtractor.
  // Row 0 is the bottom row that produces the remainder, and col 0 takes the divisor LSB.
  localparam logic [divisor_width-1:0][divisor_width-1:0] approx_cells = {
    48'h0,
    8'h01,  // row 1 col 0.
    8'h03   // row 0 col 0 and col 1.
  };

  // one job for the array.
  typedef struct packed {
    logic [dividend_width-1:0] dividend;
    logic [divisor_width-1:0]  divisor;
    logic                      approx;  // high selects the approximate cells.
  } div_op_t;

  typedef struct packed {
    logic [divisor_width-1:0] quotient;
    logic [divisor_width-1:0] remainder;
    logic                     div_by_zero;
  } div_res_t;

endpackage

`default_nettype wire

//--- rtl/div_result_regs.sv
`timescale 1ns/1ns
`default_nettype none

module div_result_regs (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  logic              valid,
  input  div_pkg::div_res_t result_in,
  output div_pkg::div_res_t result,
  output logic              done
);

  // Holds the last completed job until the next one lands.
  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
    end else if (valid) begin
      result <= result_in;
    end
  end

  // valid outranks clear because a coinciding valid belongs to the older job.
  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else if (valid) begin
      done <= 1'b1;
    end else if (clear) begin
      done <= 1'b0;  // a newer job is now in flight.
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then scan the log for failures.
set -e
set -o pipefail

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module div_tb -o div_sim

./obj_dir/div_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi
echo "simulation finished without failures"

//--- verification/div_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module div_assertions (
  input logic              clk,
  input logic              reset,
  input apb_pkg::apb_req_t apb_req,
  input apb_pkg::apb_rsp_t apb_rsp,
  input logic              start,
  input logic              valid,
  input logic              done
);

  int failures = 0;

  // the completer never inserts wait states.
  pready_high: assert property (@(posedge clk) disable iff (reset)
    apb_req.psel |-> apb_rsp.pready)
    else begin
      failures++;
      $error("pready low while the slave is selected");
    end

  penable_needs_psel: assert property (@(posedge clk) disable iff (reset)
    apb_req.penable |-> apb_req.psel)
    else begin
      failures++;
      $error("penable high without psel");
    end

  access_after_setup: assert property (@(posedge clk) disable iff (reset)
    $past(apb_req.psel && !apb_req.penable) |-> apb_req.psel && apb_req.penable)
    else begin
      failures++;
      $error("setup phase not followed by an access phase");
    end

  // start registers the job, start_q then registers the array output as valid.
  valid_after_start: assert property (@(posedge clk) disable iff (reset)
    valid == $past(start, 2))
    else begin
      failures++;
      $error("valid does not trail start by the execute latency");
    end

  done_after_write: assert property (@(posedge clk) disable iff (reset)
    $past(start, 3) |-> done)
    else begin
      failures++;
      $error("done not set after an OPERANDS write completed");
    end

  done_cleared: assert property (@(posedge clk) disable iff (reset)
    $past(start) && !$past(valid) |-> !done)
    else begin
      failures++;
      $error("done still set after a new job started");
    end

endmodule

bind div_apb_top div_assertions assertions_i (
  .clk     (clk),
  .reset   (reset),
  .apb_req (apb_req),
  .apb_rsp (apb_rsp),
  .start   (start),
  .valid   (valid),
  .done    (done)
);

`default_nettype wire

//--- verification/div_tb.sv
`timescale 1ns/1ns
`default_nettype none

module div_tb;

  localparam int num_ops         = 200;
  localparam int num_transfers   = 6 * num_ops + 60;  // three transfers per job.
  localparam int watchdog_cycles = num_transfers * 4 + 200;

  logic              clk;
  logic              reset;
  apb_pkg::apb_req_t apb_req;
  apb_pkg::apb_rsp_t apb_rsp;

  logic [31:0] seed;
  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;
  logic [15:0] dividends [num_ops];
  logic [7:0]  divisors [num_ops];
  logic [15:0] exact_results [num_ops];  // {remainder, quotient} from exact mode.

  div_apb_top dut_i (
    .clk     (clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  always #5 clk = ~clk;

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    $display("Test failures found");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic is_approx_cell(input int row, input int col);
    return (row == 0 && col <= 1) || (row == 1 && col == 0);
  endfunction

  // Restoring division one quotient bit per row, starting from the top.
  // Returns the RESULT layout, remainder over quotient.
  function automatic logic [15:0] model_divide(input logic [15:0] dividend,
                                               input logic [7:0] divisor,
                                               input logic approx);
    logic [7:0] rem;
    logic [7:0] x;
    logic [7:0] diff;
    logic [7:0] quot;
    logic       borrow;
    logic       high;
    rem = dividend[15:8];
    for (int i = 7; i >= 0; i--) begin
      x      = {rem[6:0], dividend[i]};  // shift in the next dividend bit.
      high   = rem[7];
      borrow = 1'b0;
      for (int j = 0; j < 8; j++) begin
        if (approx && is_approx_cell(i, j)) begin
          diff[j] = x[j];
          borrow  = borrow | (~x[j] & divisor[j]);
        end else begin
          diff[j] = x[j] ^ divisor[j] ^ borrow;
          borrow  = (~x[j] & divisor[j]) | (~(x[j] ^ divisor[j]) & borrow);
        end
      end
      quot[i] = high | ~borrow;
      rem     = quot[i] ? diff : x;
    end
    return {rem, quot};
  endfunction

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
    assert (got === expected) else begin
      errors++;
      $display("ERROR at %0t ns: %s is 0x%h, expected 0x%h", $time, what, got, expected);
    end
  endtask

  task automatic transfer(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                          input logic exp_err, output logic [31:0] rdata);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready) @(negedge clk);
    rdata = apb_rsp.prdata;
    expect_equal({31'h0, apb_rsp.pslverr}, {31'h0, exp_err},
                 $sformatf("pslverr at offset 0x%h", addr));
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rdata;
    transfer(1'b1, addr, data, exp_err, rdata);
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                          input logic exp_err);
    transfer(1'b0, addr, 32'h0, exp_err, data);
  endtask

  task automatic wait_for_done(output logic [31:0] status);
    int polls;
    polls = 1;
    read_reg(apb_pkg::addr_status, status, 1'b0);
    while (!status[0] && polls < 8) begin
      polls++;
      read_reg(apb_pkg::addr_status, status, 1'b0);
    end
    if (!status[0]) begin
      errors++;
      $display("done was never set, %0d status reads after the job started", polls);
    end
  endtask

  task automatic run_job(input logic [15:0] dividend, input logic [7:0] divisor,
                         input logic approx, output logic [15:0] got);
    logic [31:0] status;
    logic [31:0] rdata;
    write_reg(apb_pkg::addr_operands, {8'h00, divisor, dividend}, 1'b0);
    wait_for_done(status);
    expect_equal({31'h0, status[1]}, {31'h0, divisor == 8'h00},
                 $sformatf("divide-by-zero flag for divisor 0x%h", divisor));
    read_reg(apb_pkg::addr_result, rdata, 1'b0);
    expect_equal(rdata, {16'h0, model_divide(dividend, divisor, approx)},
                 $sformatf("RESULT of 0x%h / 0x%h", dividend, divisor));
    got = rdata[15:0];
  endtask

  task automatic begin_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %-22s passed", name);
    end else begin
      tests_failed++;
      $display("test %-22s FAILED with %0d errors", name, errors - errors_at_start);
    end
  endtask

  initial begin
    logic [31:0] rdata;
    logic [31:0] snapshot [3];
    logic [15:0] got;
    logic [7:0]  hi;
    int          diff_count;
    int          assertion_failures;
    clk          = 1'b0;
    reset        = 1'b1;
    apb_req      = '0;
    seed         = 32'h3e8e8524;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    begin_test();
    read_reg(apb_pkg::addr_status, rdata, 1'b0);
    expect_equal(rdata, 32'h0, "STATUS after reset");
    read_reg(apb_pkg::addr_result, rdata, 1'b0);
    expect_equal(rdata, 32'h0, "RESULT after reset");
    read_reg(apb_pkg::addr_mode, rdata, 1'b0);
    expect_equal(rdata, 32'h1, "MODE after reset");
    end_test("reset values");

    begin_test();
    write_reg(apb_pkg::addr_mode, 32'h0, 1'b0);
    read_reg(apb_pkg::addr_mode, rdata, 1'b0);
    expect_equal(rdata, 32'h0, "MODE after selecting exact cells");
    for (int n = 0; n < num_ops; n++) begin
      seed        = lcg_next(seed);
      divisors[n] = (seed[31:24] == 8'h00) ? 8'h01 : seed[31:24];
      seed        = lcg_next(seed);
      hi          = seed[31:24] % divisors[n];  // keeps the quotient within 8 bits.
      dividends[n] = {hi, seed[23:16]};
      run_job(dividends[n], divisors[n], 1'b0, got);
      exact_results[n] = got;
      expect_equal({16'h0, got}, {16'h0, 8'(dividends[n] % divisors[n]),
                   8'(dividends[n] / divisors[n])}, "exact result against integer division");
    end
    end_test("exact mode");

    begin_test();
    diff_count = 0;
    write_reg(apb_pkg::addr_mode, 32'h1, 1'b0);
    for (int n = 0; n < num_ops; n++) begin
      run_job(dividends[n], divisors[n], 1'b1, got);
      if (got != exact_results[n]) diff_count++;
    end
    assert (diff_count > 0) else begin
      errors++;
      $display("approximate mode matched exact mode for all %0d operand pairs", num_ops);
    end
    end_test("approximate mode");

    begin_test();
    for (int m = 0; m < 2; m++) begin
      write_reg(apb_pkg::addr_mode, m, 1'b0);
      seed = lcg_next(seed);
      run_job(seed[31:16], 8'h00, m[0], got);
      run_job(16'h1234, 8'h56, m[0], got);  // the flag drops again for a real divisor.
    end
    end_test("zero divisor");

    begin_test();
    read_reg(apb_pkg::addr_result, snapshot[0], 1'b0);
    read_reg(apb_pkg::addr_status, snapshot[1], 1'b0);
    read_reg(apb_pkg::addr_mode, snapshot[2], 1'b0);
    write_reg(4'h2, 32'h0, 1'b1);
    read_reg(4'h6, rdata, 1'b1);
    write_reg(apb_pkg::addr_result, 32'hffff_ffff, 1'b1);
    write_reg(apb_pkg::addr_status, 32'h0, 1'b1);
    read_reg(apb_pkg::addr_operands, rdata, 1'b1);
    read_reg(apb_pkg::addr_result, rdata, 1'b0);
    expect_equal(rdata, snapshot[0], "RESULT after rejected accesses");
    read_reg(apb_pkg::addr_status, rdata, 1'b0);
    expect_equal(rdata, snapshot[1], "STATUS after rejected accesses");
    read_reg(apb_pkg::addr_mode, rdata, 1'b0);
    expect_equal(rdata, snapshot[2], "MODE after rejected accesses");
    end_test("slave errors");

    begin_test();
    seed = lcg_next(seed);
    run_job(seed[31:16], seed[15:8], 1'b1, got);
    // this job completes but the next write replaces it before its result is read.
    write_reg(apb_pkg::addr_operands, {8'h00, 8'h9b, 16'h4c21}, 1'b0);
    run_job(16'h7e05, 8'hc3, 1'b1, got);
    end_test("done tracking");

    assertion_failures = dut_i.assertions_i.failures;
    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, assertion_failures);
    if (errors == 0 && assertion_failures == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
